/* logic/fpu_params.svh */
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// single precision word format
`define FPU_EXP_W    8
`define FPU_MANT_W   23

`define FPU_BIAS     127
`define FPU_EXP_MAX  255   // all-ones exponent, inf or nan

// quiet nan returned for any nan operand
`define FPU_QNAN     32'h7FC0_0000

`endif

/* logic/fpu_pkg.sv */
`include "fpu_params.svh"

package fpu_pkg;

    ////////////////////////////////////////////////////////////
    // word layout
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                   sign;
        logic [`FPU_EXP_W-1:0]  exp;
        logic [`FPU_MANT_W-1:0] mant;
    } fp_fields_t;

    // same 32 bits seen raw or split into fields
    typedef union packed {
        logic [31:0] raw;
        fp_fields_t  f;
    } fp_word_u;

    typedef struct packed {
        logic zero;
        logic inf;
        logic nan;
    } fp_class_t;

    ////////////////////////////////////////////////////////////
    // control and working types
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        FP_ADD = 1'b0,
        FP_MUL = 1'b1
    } fp_op_e;

    // what stage two does with the operation
    typedef enum logic [1:0] {
        KIND_NORM = 2'd0,
        KIND_ZERO = 2'd1,
        KIND_INF  = 2'd2,
        KIND_NAN  = 2'd3
    } fp_kind_e;

    // room below 0 and above 255 for flush and overflow
    typedef logic signed [`FPU_EXP_W+1:0] fp_exp_t;

    // bit 24 carry, bit 23 hidden one
    typedef logic [`FPU_MANT_W+1:0] fp_sig_t;

endpackage

/* logic/fp_stage_if.sv */
`timescale 1ns/1ps

interface fp_stage_if;
    import fpu_pkg::*;

    logic     valid;   // high while the stage holds an op
    fp_kind_e kind;
    logic     sign;
    fp_exp_t  exp;
    fp_sig_t  sig;

    modport issue (output valid, kind, sign, exp, sig);
    modport pack  (input  valid, kind, sign, exp, sig);

endinterface

/* logic/fp_classify.sv */
`timescale 1ns/1ps
`include "fpu_params.svh"

module fp_classify (
    input  fpu_pkg::fp_word_u   word,
    output fpu_pkg::fp_fields_t fields,
    output fpu_pkg::fp_class_t  cls
);

    logic exp_zero;
    logic exp_ones;
    logic mant_zero;

    assign fields = word.f;

    assign exp_zero  = (word.f.exp == '0);
    assign exp_ones  = (word.f.exp == `FPU_EXP_MAX);
    assign mant_zero = (word.f.mant == '0);

    // denormals count as zero
    assign cls.zero = exp_zero;
    assign cls.inf  = exp_ones & mant_zero;
    assign cls.nan  = exp_ones & ~mant_zero;

endmodule

/* logic/fp_add_path.sv */
`timescale 1ns/1ps

module fp_add_path (
    input  fpu_pkg::fp_fields_t f1,
    input  fpu_pkg::fp_fields_t f2,
    output logic                sign,
    output fpu_pkg::fp_exp_t    exp,
    output fpu_pkg::fp_sig_t    sig,
    output logic                cancel
);
    import fpu_pkg::*;

    fp_fields_t big;
    fp_fields_t lesser;
    logic       swap;
    logic       sub;
    logic [7:0] exp_diff;
    fp_sig_t    big_sig;
    fp_sig_t    small_sig;

    ////////////////////////////////////////////////////////////
    // order by magnitude
    ////////////////////////////////////////////////////////////

    // exp above mant, so one compare orders the magnitudes
    assign swap   = {f2.exp, f2.mant} > {f1.exp, f1.mant};
    assign big    = swap ? f2 : f1;
    assign lesser = swap ? f1 : f2;

    assign exp_diff = big.exp - lesser.exp;

    ////////////////////////////////////////////////////////////
    // align and add
    ////////////////////////////////////////////////////////////

    assign big_sig   = {2'b01, big.mant};
    assign small_sig = fp_sig_t'({2'b01, lesser.mant}) >> exp_diff;  // bits shifted out are lost

    assign sub = f1.sign ^ f2.sign;

    // big >= small after alignment, so no borrow
    assign sig = sub ? (big_sig - small_sig) : (big_sig + small_sig);

    assign sign = big.sign;  // equal signs give the common one anyway
    assign exp  = fp_exp_t'(big.exp);

    // only equal magnitudes leave nothing
    assign cancel = sub & (sig == '0);

endmodule

/* logic/fp_mul_path.sv */
`timescale 1ns/1ps
`include "fpu_params.svh"

module fp_mul_path (
    input  fpu_pkg::fp_fields_t f1,
    input  fpu_pkg::fp_fields_t f2,
    output logic                sign,
    output fpu_pkg::fp_exp_t    exp,
    output fpu_pkg::fp_sig_t    sig
);
    import fpu_pkg::*;

    logic [23:0] sig1;
    logic [23:0] sig2;
    logic [47:0] prod;

    assign sig1 = {1'b1, f1.mant};
    assign sig2 = {1'b1, f2.mant};

    // 1.x times 1.y lands in [1,4), top bit is the carry
    assign prod = sig1 * sig2;

    // bit 47 as carry, bit 46 as hidden one
    assign sig = prod[47:23];

    assign exp = fp_exp_t'(f1.exp) + fp_exp_t'(f2.exp)
               - fp_exp_t'(`FPU_BIAS);

    assign sign = f1.sign ^ f2.sign;

endmodule

/* logic/fp_issue_stage.sv */
`timescale 1ns/1ps

module fp_issue_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  fpu_pkg::fp_op_e     op,
    input  fpu_pkg::fp_class_t  c1,
    input  fpu_pkg::fp_class_t  c2,
    input  fpu_pkg::fp_fields_t f1,
    input  fpu_pkg::fp_fields_t f2,
    input  logic                add_sign,
    input  fpu_pkg::fp_exp_t    add_exp,
    input  fpu_pkg::fp_sig_t    add_sig,
    input  logic                add_cancel,
    input  logic                mul_sign,
    input  fpu_pkg::fp_exp_t    mul_exp,
    input  fpu_pkg::fp_sig_t    mul_sig,
    fp_stage_if.issue           stage
);
    import fpu_pkg::*;

    fp_kind_e kind_d;
    logic     sign_d;
    fp_exp_t  exp_d;
    fp_sig_t  sig_d;

    ////////////////////////////////////////////////////////////
    // special operand table, first match wins
    ////////////////////////////////////////////////////////////

    always_comb begin
        kind_d = KIND_NORM;
        sign_d = 1'b0;
        exp_d  = '0;
        sig_d  = '0;
        if (c1.nan || c2.nan) begin
            kind_d = KIND_NAN;
        end else if (op == FP_ADD) begin
            if ((c1.zero && c2.zero) || add_cancel ||
                (c1.inf && c2.inf && (f1.sign != f2.sign))) begin
                kind_d = KIND_ZERO;
            end else if (c1.inf || c2.inf) begin
                kind_d = KIND_INF;
                sign_d = c1.inf ? f1.sign : f2.sign;
            end else if (c1.zero || c2.zero) begin
                // pass the nonzero operand on untouched
                sign_d = c1.zero ? f2.sign : f1.sign;
                exp_d  = fp_exp_t'(c1.zero ? f2.exp : f1.exp);
                sig_d  = {2'b01, (c1.zero ? f2.mant : f1.mant)};
            end else begin
                sign_d = add_sign;
                exp_d  = add_exp;
                sig_d  = add_sig;
            end
        end else begin
            if (c1.zero || c2.zero) begin
                kind_d = KIND_ZERO;  // zero times inf too
            end else if (c1.inf || c2.inf) begin
                kind_d = KIND_INF;
                sign_d = f1.sign ^ f2.sign;
            end else begin
                sign_d = mul_sign;
                exp_d  = mul_exp;
                sig_d  = mul_sig;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stage one register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage.valid <= 1'b0;
        end else begin
            stage.valid <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            stage.kind <= kind_d;
            stage.sign <= sign_d;
            stage.exp  <= exp_d;
            stage.sig  <= sig_d;
        end
    end

endmodule

/* logic/fp_normalize_pack.sv */
`timescale 1ns/1ps
`include "fpu_params.svh"

module fp_normalize_pack (
    input  logic              clk,
    input  logic              arst_n,
    fp_stage_if.pack          stage,
    output fpu_pkg::fp_word_u result,
    output logic              done
);
    import fpu_pkg::*;

    logic [4:0] lead_shift;
    fp_sig_t    norm_sig;
    fp_exp_t    norm_exp;
    fp_word_u   word_d;

    ////////////////////////////////////////////////////////////
    // leading one search
    ////////////////////////////////////////////////////////////

    // upward scan, the highest set bit wins
    always_comb begin
        lead_shift = '0;
        for (int i = 0; i < 24; i++) begin
            if (stage.sig[i]) begin
                lead_shift = 5'(23 - i);
            end
        end
    end

    always_comb begin
        if (stage.sig[24]) begin
            norm_sig = stage.sig >> 1;  // carry out, drop the low bit
            norm_exp = stage.exp + fp_exp_t'(1);
        end else begin
            norm_sig = stage.sig << lead_shift;
            norm_exp = stage.exp - fp_exp_t'(lead_shift);
        end
    end

    ////////////////////////////////////////////////////////////
    // pack
    ////////////////////////////////////////////////////////////

    always_comb begin
        word_d.raw = '0;
        case (stage.kind)
            KIND_NORM: begin
                if (norm_exp <= 0) begin
                    word_d.raw = '0;  // flush to +0
                end else if (norm_exp >= `FPU_EXP_MAX) begin
                    word_d.f.sign = stage.sign;
                    word_d.f.exp  = '1;
                end else begin
                    word_d.f.sign = stage.sign;
                    word_d.f.exp  = norm_exp[7:0];
                    word_d.f.mant = norm_sig[22:0];
                end
            end
            KIND_INF: begin
                word_d.f.sign = stage.sign;
                word_d.f.exp  = '1;
            end
            KIND_NAN: word_d.raw = `FPU_QNAN;
            default:  word_d.raw = '0;  // zero is always +0
        endcase
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            done   <= 1'b0;
        end else begin
            done <= stage.valid;
            if (stage.valid) begin
                result <= word_d;  // held between results
            end
        end
    end

endmodule

/* logic/fpu.sv */
`timescale 1ns/1ps

module fpu (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            start,
    input  fpu_pkg::fp_op_e op,
    input  logic [31:0]     a,
    input  logic [31:0]     b,
    output logic [31:0]     result,
    output logic            done
);
    import fpu_pkg::*;

    fp_fields_t f1;
    fp_fields_t f2;
    fp_class_t  c1;
    fp_class_t  c2;

    logic       add_sign;
    fp_exp_t    add_exp;
    fp_sig_t    add_sig;
    logic       add_cancel;
    logic       mul_sign;
    fp_exp_t    mul_exp;
    fp_sig_t    mul_sig;

    fp_stage_if u_stage ();

    ////////////////////////////////////////////////////////////
    // stage one, decode and both datapaths
    ////////////////////////////////////////////////////////////

    fp_classify u_classify_a (.word(a), .fields(f1), .cls(c1));
    fp_classify u_classify_b (.word(b), .fields(f2), .cls(c2));

    fp_add_path u_add_path (
        .f1     (f1),
        .f2     (f2),
        .sign   (add_sign),
        .exp    (add_exp),
        .sig    (add_sig),
        .cancel (add_cancel)
    );

    fp_mul_path u_mul_path (
        .f1   (f1),
        .f2   (f2),
        .sign (mul_sign),
        .exp  (mul_exp),
        .sig  (mul_sig)
    );

    fp_issue_stage u_issue (
        .clk        (clk),
        .arst_n     (arst_n),
        .start      (start),
        .op         (op),
        .c1         (c1),
        .c2         (c2),
        .f1         (f1),
        .f2         (f2),
        .add_sign   (add_sign),
        .add_exp    (add_exp),
        .add_sig    (add_sig),
        .add_cancel (add_cancel),
        .mul_sign   (mul_sign),
        .mul_exp    (mul_exp),
        .mul_sig    (mul_sig),
        .stage      (u_stage)
    );

    // stage two
    fp_normalize_pack u_pack (
        .clk    (clk),
        .arst_n (arst_n),
        .stage  (u_stage),
        .result (result),
        .done   (done)
    );

endmodule

/* tb/fpu_chk.sv */
`timescale 1ns/1ps

module fpu_chk (
    input logic        clk,
    input logic        arst_n,
    input logic        start,
    input logic        done,
    input logic [31:0] result
);

    // two register stages between start and done
    a_done_follows_start: assert property (
        @(posedge clk) disable iff (!arst_n) done == $past(start, 2)
    ) else $error("done does not trail start by two cycles");

    a_done_low_in_reset: assert property (
        @(posedge clk) !arst_n |-> !done
    ) else $error("done high during reset");

    a_result_known: assert property (
        @(posedge clk) disable iff (!arst_n) done |-> !$isunknown(result)
    ) else $error("result has unknown bits while done is high");

endmodule

bind fpu fpu_chk u_fpu_chk (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .done   (done),
    .result (result)
);

/* tb/fpu_ref.svh */
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

`include "fpu_params.svh"

// flush low exponents to +0, saturate high ones to a signed infinity
function automatic fpu_pkg::fp_word_u pack_word(input logic s, input int e,
                                                input logic [22:0] m);
    fpu_pkg::fp_word_u w;
    w.raw = 32'h0;
    if (e >= `FPU_EXP_MAX) begin
        w.raw = {s, 8'hFF, 23'h0};
    end else if (e > 0) begin
        w.raw = {s, e[7:0], m};
    end
    return w;
endfunction

// truncating add and multiply, denormal inputs read as zero
function automatic fpu_pkg::fp_word_u fpu_model(
    input fpu_pkg::fp_op_e op_sel,
    input logic [31:0]     x,
    input logic [31:0]     y
);
    fpu_pkg::fp_word_u w;
    logic        sx, sy, s;
    logic        inf_x, inf_y, nan_x, nan_y;
    int          ex, ey, e;
    logic [63:0] mx, my, big, lesser, acc;

    sx    = x[31];
    sy    = y[31];
    ex    = int'(x[30:23]);
    ey    = int'(y[30:23]);
    mx    = {40'h0, 1'b1, x[22:0]};
    my    = {40'h0, 1'b1, y[22:0]};
    inf_x = (ex == `FPU_EXP_MAX) && (x[22:0] == 23'h0);
    inf_y = (ey == `FPU_EXP_MAX) && (y[22:0] == 23'h0);
    nan_x = (ex == `FPU_EXP_MAX) && (x[22:0] != 23'h0);
    nan_y = (ey == `FPU_EXP_MAX) && (y[22:0] != 23'h0);
    w.raw = 32'h0;  // +0 unless a rule below applies

    if (nan_x || nan_y) begin
        w.raw = `FPU_QNAN;
    end else if (op_sel == fpu_pkg::FP_ADD) begin
        if (inf_x && inf_y) begin
            w.raw = (sx == sy) ? {sx, 8'hFF, 23'h0} : 32'h0;
        end else if (inf_x || inf_y) begin
            w.raw = {(inf_x ? sx : sy), 8'hFF, 23'h0};
        end else if (ex == 0 && ey != 0) begin
            w.raw = y;
        end else if (ey == 0 && ex != 0) begin
            w.raw = x;
        end else if (ex != 0) begin
            // larger magnitude keeps exponent and sign
            if (x[30:0] >= y[30:0]) begin
                big    = mx;
                lesser = my >> (ex - ey);
                e      = ex;
                s      = sx;
            end else begin
                big    = my;
                lesser = mx >> (ey - ex);
                e      = ey;
                s      = sy;
            end
            acc = (sx == sy) ? big + lesser : big - lesser;
            if (acc != 64'h0) begin
                if (acc[24]) begin
                    acc = acc >> 1;
                    e   = e + 1;
                end
                while (!acc[23]) begin
                    acc = acc << 1;
                    e   = e - 1;
                end
                w = pack_word(s, e, acc[22:0]);
            end
        end
    end else if (ex != 0 && ey != 0) begin
        if (inf_x || inf_y) begin
            w.raw = {sx ^ sy, 8'hFF, 23'h0};
        end else begin
            acc = mx * my;
            e   = ex + ey - `FPU_BIAS;
            if (acc[47]) begin
                w = pack_word(sx ^ sy, e + 1, acc[46:24]);
            end else begin
                w = pack_word(sx ^ sy, e, acc[45:23]);
            end
        end
    end
    return w;
endfunction

`endif

/* tb/fpu_tb.sv */
`timescale 1ns/1ps
`include "fpu_params.svh"

module fpu_tb;
    import fpu_pkg::*;

    `include "fpu_ref.svh"

    logic        clk;
    logic        arst_n;
    logic        start;
    fp_op_e      op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic        done;

    fp_word_u    expect_q[$];  // model results in issue order
    int          n_done = 0;
    int          seed;
    logic [1:0]  start_hist = '0;

    fpu u_fpu (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic fail_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_result(input fp_word_u got, input fp_word_u want);
        if (got.raw !== want.raw) begin
            $display("MISMATCH result: got %h expected %h (result %0d)",
                     got.raw, want.raw, n_done);
            fail_run();
        end
    endtask

    task automatic check_done(input logic want, input logic got);
        if (got !== want) begin
            $display("MISMATCH done: got %h expected %h", got, want);
            fail_run();
        end
    endtask

    // done must repeat start two samples later
    always @(negedge clk) begin
        check_done(start_hist[1], done);
        start_hist = {start_hist[0], start};
        if (done) begin
            if (expect_q.size() == 0) begin
                $display("done pulse with no operation pending");
                fail_run();
            end else begin
                check_result(fp_word_u'(result), expect_q.pop_front());
                n_done++;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic drive_op(input fp_op_e op_sel, input logic [31:0] x,
                            input logic [31:0] y);
        fp_word_u want;
        want = fpu_model(op_sel, x, y);
        @(posedge clk);
        start <= 1'b1;
        op    <= op_sel;
        a     <= x;
        b     <= y;
        expect_q.push_back(want);
    endtask

    task automatic go_idle();
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_drain(input int max_cycles);
        int cycles;
        cycles = 0;
        while (expect_q.size() != 0) begin
            @(posedge clk);
            cycles++;
            if (cycles > max_cycles) begin
                $display("timeout with %0d results pending", expect_q.size());
                fail_run();
            end
        end
    endtask

    task automatic run_one(input fp_op_e op_sel, input logic [31:0] x,
                           input logic [31:0] y);
        drive_op(op_sel, x, y);
        go_idle();
        wait_drain(20);
    endtask

    // exponents mostly near the bias, so cancellation and products in range
    function automatic logic [31:0] rand_word();
        logic [31:0] w;
        logic [31:0] k;
        w = $random(seed);
        k = $random(seed);
        if (k[1:0] != 2'b00) begin
            w[30:23] = 8'd120 + {5'd0, k[4:2]};
        end
        return w;
    endfunction

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rk;
        seed     = 32'h2663_51e6;
        arst_n   = 1'b0;
        start    = 1'b0;
        op       = FP_ADD;
        a        = '0;
        b        = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        check_result(fp_word_u'(result), fp_word_u'(32'h0));
        repeat (10) @(posedge clk);  // done checked on every idle cycle

        // same sign add
        run_one(FP_ADD, 32'h3F80_0000, 32'h3F80_0000);
        run_one(FP_ADD, 32'h3FC0_0000, 32'h4010_0000);
        run_one(FP_ADD, 32'h4B00_0000, 32'h3F80_0000);
        run_one(FP_ADD, 32'hBF80_0000, 32'hC000_0000);
        run_one(FP_ADD, 32'h7F7F_FFFF, 32'h7F7F_FFFF);  // carry into inf
        // different sign add
        run_one(FP_ADD, 32'h3F80_0000, 32'hBF80_0000);
        run_one(FP_ADD, 32'h3F80_0001, 32'hBF80_0000);
        run_one(FP_ADD, 32'h4040_0000, 32'hBF80_0000);
        run_one(FP_ADD, 32'hC040_0000, 32'h3F80_0000);
        run_one(FP_ADD, 32'h0080_0001, 32'h8080_0000);  // flush to +0
        // multiply
        run_one(FP_MUL, 32'h3FC0_0000, 32'h3FC0_0000);
        run_one(FP_MUL, 32'h4000_0000, 32'h4040_0000);
        run_one(FP_MUL, 32'hBF80_0000, 32'h4000_0000);
        run_one(FP_MUL, 32'h7F00_0000, 32'h7F00_0000);
        run_one(FP_MUL, 32'hFF00_0000, 32'h7F00_0000);
        run_one(FP_MUL, 32'h0080_0000, 32'h0080_0000);
        // special operands
        run_one(FP_ADD, 32'h7FC0_0001, 32'h3F80_0000);
        run_one(FP_MUL, 32'h3F80_0000, 32'hFF80_0001);
        run_one(FP_ADD, 32'h7F80_0000, 32'hFF80_0000);
        run_one(FP_MUL, 32'h0000_0000, 32'h7F80_0000);
        run_one(FP_ADD, 32'h0000_0000, 32'h4049_0FDB);
        run_one(FP_ADD, 32'hC049_0FDB, 32'h8000_0000);
        run_one(FP_ADD, 32'h0040_0000, 32'h3F80_0000);
        run_one(FP_MUL, 32'hFF80_0000, 32'h3F80_0000);

        // back-to-back ops with start held high
        for (int i = 0; i < 2000; i++) begin
            rk = $random(seed);
            ra = rand_word();
            rb = rand_word();
            drive_op(rk[0] ? FP_MUL : FP_ADD, ra, rb);
        end
        go_idle();
        wait_drain(20);
        repeat (5) @(posedge clk);  // stray done pulses fail in the compare process

        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* fpu.f */
+incdir+logic
+incdir+tb
logic/fpu_pkg.sv
logic/fp_stage_if.sv
logic/fp_classify.sv
logic/fp_add_path.sv
logic/fp_mul_path.sv
logic/fp_issue_stage.sv
logic/fp_normalize_pack.sv
logic/fpu.sv
tb/fpu_chk.sv
tb/fpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the fpu testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module fpu_tb \
        -f fpu.f -o Vfpu_tb; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vfpu_tb > sim.log 2>&1
run_status=$?
cat sim.log

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
